//--- hdl/wb_pkg.sv
package wb_pkg;

    // data and index widths
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [13:0] csr_num_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [2:0]  csr_op_t;
    // {adef, brk, ine, ale}
    typedef logic [3:0]  exc_flags_t;

    // retire operation kinds
    localparam csr_op_t OP_NONE    = 3'd0;
    localparam csr_op_t OP_CSRRD   = 3'd1;
    localparam csr_op_t OP_CSRWR   = 3'd2;
    localparam csr_op_t OP_CSRXCHG = 3'd3;
    localparam csr_op_t OP_ERTN    = 3'd4;
    localparam csr_op_t OP_SYSCALL = 3'd5;

    // bit positions inside exc_flags_t
    localparam int EXC_ADEF = 3;
    localparam int EXC_BRK  = 2;
    localparam int EXC_INE  = 1;
    localparam int EXC_ALE  = 0;

    // implemented CSR numbers
    localparam csr_num_t CSR_CRMD   = 14'h00;
    localparam csr_num_t CSR_PRMD   = 14'h01;
    localparam csr_num_t CSR_ESTAT  = 14'h05;
    localparam csr_num_t CSR_ERA    = 14'h06;
    localparam csr_num_t CSR_EENTRY = 14'h0c;
    localparam csr_num_t CSR_SAVE0  = 14'h30;
    localparam csr_num_t CSR_SAVE1  = 14'h31;
    localparam csr_num_t CSR_SAVE2  = 14'h32;
    localparam csr_num_t CSR_SAVE3  = 14'h33;

    // exception codes
    localparam ecode_t ECODE_ADE = 6'h08;
    localparam ecode_t ECODE_ALE = 6'h09;
    localparam ecode_t ECODE_SYS = 6'h0b;
    localparam ecode_t ECODE_BRK = 6'h0c;
    localparam ecode_t ECODE_INE = 6'h0d;

    // DA set, PLV and IE clear
    localparam word_t CRMD_RESET = 32'h0000_0008;

    // software writable bits per register
    localparam word_t CRMD_WMASK   = 32'h0000_0007;
    localparam word_t PRMD_WMASK   = 32'h0000_0007;
    localparam word_t ESTAT_WMASK  = 32'h0000_0003;
    localparam word_t ERA_WMASK    = 32'hffff_ffff;
    localparam word_t EENTRY_WMASK = 32'hffff_ffc0;
    localparam word_t SAVE_WMASK   = 32'hffff_ffff;

endpackage

//--- hdl/wb_decode.sv
`timescale 1ns/1ps

module wb_decode (
    input  logic               clk,
    input  logic               reset,
    input  logic               ms_to_ws_valid,
    input  wb_pkg::word_t      ms_pc,
    input  logic               ms_gr_we,
    input  wb_pkg::reg_addr_t  ms_dest,
    input  wb_pkg::word_t      ms_result,
    input  wb_pkg::csr_op_t    ms_op,
    input  wb_pkg::csr_num_t   ms_csr_num,
    input  wb_pkg::word_t      ms_rj_value,
    input  wb_pkg::word_t      ms_rkd_value,
    input  wb_pkg::exc_flags_t ms_exc,
    output logic               ws_allowin,
    output logic               ws_valid,
    output wb_pkg::word_t      pc,
    output logic               gr_we,
    output wb_pkg::reg_addr_t  dest,
    output wb_pkg::word_t      result,
    output logic               is_csr_read,
    output wb_pkg::csr_num_t   csr_num,
    output logic               csr_we,
    output wb_pkg::word_t      csr_wmask,
    output wb_pkg::word_t      csr_wvalue,
    output logic               ex_valid,
    output wb_pkg::ecode_t     ex_ecode,
    output logic               ertn_valid,
    output logic               wb_flush
);
    import wb_pkg::*;

    logic       ws_ready_go;
    logic       accept;
    csr_op_t    op;
    exc_flags_t exc;
    word_t      rj_value;
    word_t      rkd_value;
    logic       is_csrrd;
    logic       is_csrwr;
    logic       is_csrxchg;
    logic       is_syscall;
    logic       ex_hit;

    // single cycle stage, never stalls
    assign ws_ready_go = 1'b1;
    assign ws_allowin  = !ws_valid || ws_ready_go;
    assign accept      = ms_to_ws_valid && ws_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
            op       <= OP_NONE;
            gr_we    <= 1'b0;
            exc      <= '0;
        end else begin
            // a flush drops both the current and any incoming item
            if (wb_flush) begin
                ws_valid <= 1'b0;
            end else if (ws_allowin) begin
                ws_valid <= ms_to_ws_valid;
            end
            if (accept) begin
                op    <= ms_op;
                gr_we <= ms_gr_we;
                exc   <= ms_exc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pc        <= ms_pc;
            dest      <= ms_dest;
            result    <= ms_result;
            csr_num   <= ms_csr_num;
            rj_value  <= ms_rj_value;
            rkd_value <= ms_rkd_value;
        end
    end

    assign is_csrrd   = (op == OP_CSRRD);
    assign is_csrwr   = (op == OP_CSRWR);
    assign is_csrxchg = (op == OP_CSRXCHG);
    assign is_syscall = (op == OP_SYSCALL);

    assign is_csr_read = is_csrrd | is_csrwr | is_csrxchg;

    assign ex_hit     = is_syscall | (|exc);
    assign ex_valid   = ws_valid & ex_hit;
    assign ertn_valid = ws_valid & (op == OP_ERTN) & ~ex_hit;
    assign wb_flush   = ex_valid | ertn_valid;

    // csrxchg only touches the bits selected by rj
    assign csr_we     = ws_valid & (is_csrwr | is_csrxchg) & ~ex_hit;
    assign csr_wmask  = is_csrxchg ? rj_value : (is_csrwr ? '1 : '0);
    assign csr_wvalue = rkd_value;

    always_comb begin
        if (is_syscall) begin
            ex_ecode = ECODE_SYS;
        end else if (exc[EXC_BRK]) begin
            ex_ecode = ECODE_BRK;
        end else if (exc[EXC_ADEF]) begin
            ex_ecode = ECODE_ADE;
        end else if (exc[EXC_INE]) begin
            ex_ecode = ECODE_INE;
        end else if (exc[EXC_ALE]) begin
            ex_ecode = ECODE_ALE;
        end else begin
            ex_ecode = '0;
        end
    end

endmodule

//--- hdl/csr_file.sv
`timescale 1ns/1ps

module csr_file (
    input  logic             clk,
    input  logic             reset,
    input  wb_pkg::csr_num_t csr_num,
    input  logic             csr_we,
    input  wb_pkg::word_t    csr_wmask,
    input  wb_pkg::word_t    csr_wvalue,
    input  logic             ex_valid,
    input  wb_pkg::ecode_t   ex_ecode,
    input  wb_pkg::word_t    ex_pc,
    input  logic             ertn_valid,
    output wb_pkg::word_t    csr_rvalue,
    output wb_pkg::word_t    era_value,
    output wb_pkg::word_t    eentry_value
);
    import wb_pkg::*;

    word_t crmd;
    word_t prmd;
    word_t estat;
    word_t era;
    word_t eentry;
    word_t save_q [4];

    logic  wr_crmd;
    logic  wr_prmd;
    logic  wr_estat;
    logic  wr_era;
    logic  wr_eentry;

    // keep bits outside the combined mask
    function automatic word_t merge(input word_t old_val, input word_t new_val,
                                    input word_t sw_mask, input word_t field_mask);
        word_t m;
        m = sw_mask & field_mask;
        return (old_val & ~m) | (new_val & m);
    endfunction

    assign wr_crmd   = csr_we && (csr_num == CSR_CRMD);
    assign wr_prmd   = csr_we && (csr_num == CSR_PRMD);
    assign wr_estat  = csr_we && (csr_num == CSR_ESTAT);
    assign wr_era    = csr_we && (csr_num == CSR_ERA);
    assign wr_eentry = csr_we && (csr_num == CSR_EENTRY);

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd   <= CRMD_RESET;
            prmd   <= '0;
            estat  <= '0;
            era    <= '0;
            eentry <= '0;
            for (int i = 0; i < 4; i++) begin
                save_q[i] <= '0;
            end
        end else if (ex_valid) begin
            // PPLV/PIE share the bit layout of PLV/IE
            prmd[2:0]    <= crmd[2:0];
            crmd[2:0]    <= 3'b000;
            estat[21:16] <= ex_ecode;
            era          <= ex_pc;
        end else if (ertn_valid) begin
            crmd[2:0] <= prmd[2:0];
        end else begin
            if (wr_crmd) begin
                crmd <= merge(crmd, csr_wvalue, csr_wmask, CRMD_WMASK);
            end
            if (wr_prmd) begin
                prmd <= merge(prmd, csr_wvalue, csr_wmask, PRMD_WMASK);
            end
            if (wr_estat) begin
                estat <= merge(estat, csr_wvalue, csr_wmask, ESTAT_WMASK);
            end
            if (wr_era) begin
                era <= merge(era, csr_wvalue, csr_wmask, ERA_WMASK);
            end
            if (wr_eentry) begin
                eentry <= merge(eentry, csr_wvalue, csr_wmask, EENTRY_WMASK);
            end
            for (int i = 0; i < 4; i++) begin
                if (csr_we && (csr_num == CSR_SAVE0 + csr_num_t'(i))) begin
                    save_q[i] <= merge(save_q[i], csr_wvalue, csr_wmask, SAVE_WMASK);
                end
            end
        end
    end

    // unimplemented numbers read zero
    always_comb begin
        case (csr_num)
            CSR_CRMD:   csr_rvalue = crmd;
            CSR_PRMD:   csr_rvalue = prmd;
            CSR_ESTAT:  csr_rvalue = estat;
            CSR_ERA:    csr_rvalue = era;
            CSR_EENTRY: csr_rvalue = eentry;
            CSR_SAVE0:  csr_rvalue = save_q[0];
            CSR_SAVE1:  csr_rvalue = save_q[1];
            CSR_SAVE2:  csr_rvalue = save_q[2];
            CSR_SAVE3:  csr_rvalue = save_q[3];
            default:    csr_rvalue = '0;
        endcase
    end

    assign era_value    = era;
    assign eentry_value = eentry;

endmodule

//--- hdl/wb_result.sv
`timescale 1ns/1ps

module wb_result (
    input  logic              ws_valid,
    input  logic              gr_we,
    input  wb_pkg::reg_addr_t dest,
    input  wb_pkg::word_t     result,
    input  logic              is_csr_read,
    input  wb_pkg::word_t     csr_rvalue,
    input  logic              ex_valid,
    input  logic              ertn_valid,
    input  wb_pkg::word_t     era_value,
    input  wb_pkg::word_t     eentry_value,
    output logic              rf_we,
    output wb_pkg::reg_addr_t rf_waddr,
    output wb_pkg::word_t     rf_wdata,
    output wb_pkg::word_t     flush_pc
);

    // an excepting instruction never reaches the register file
    assign rf_we    = ws_valid & gr_we & ~ex_valid;
    assign rf_waddr = dest;

    // csr instructions return the old csr value in rd
    assign rf_wdata = is_csr_read ? csr_rvalue : result;

    // ertn returns to ERA, everything else enters at EENTRY
    assign flush_pc = ertn_valid ? era_value : eentry_value;

endmodule

//--- hdl/wb_stage.sv
`timescale 1ns/1ps

module wb_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               ms_to_ws_valid,
    input  wb_pkg::word_t      ms_pc,
    input  logic               ms_gr_we,
    input  wb_pkg::reg_addr_t  ms_dest,
    input  wb_pkg::word_t      ms_result,
    input  wb_pkg::csr_op_t    ms_op,
    input  wb_pkg::csr_num_t   ms_csr_num,
    input  wb_pkg::word_t      ms_rj_value,
    input  wb_pkg::word_t      ms_rkd_value,
    input  wb_pkg::exc_flags_t ms_exc,
    output logic               ws_allowin,
    output logic               rf_we,
    output wb_pkg::reg_addr_t  rf_waddr,
    output wb_pkg::word_t      rf_wdata,
    output logic               wb_flush,
    output wb_pkg::word_t      flush_pc
);
    import wb_pkg::*;

    logic      ws_valid;
    word_t     pc;
    logic      gr_we;
    reg_addr_t dest;
    word_t     result;
    logic      is_csr_read;
    csr_num_t  csr_num;
    logic      csr_we;
    word_t     csr_wmask;
    word_t     csr_wvalue;
    logic      ex_valid;
    ecode_t    ex_ecode;
    logic      ertn_valid;
    word_t     csr_rvalue;
    word_t     era_value;
    word_t     eentry_value;

    wb_decode u_decode (
        .clk            (clk),
        .reset          (reset),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_pc          (ms_pc),
        .ms_gr_we       (ms_gr_we),
        .ms_dest        (ms_dest),
        .ms_result      (ms_result),
        .ms_op          (ms_op),
        .ms_csr_num     (ms_csr_num),
        .ms_rj_value    (ms_rj_value),
        .ms_rkd_value   (ms_rkd_value),
        .ms_exc         (ms_exc),
        .ws_allowin     (ws_allowin),
        .ws_valid       (ws_valid),
        .pc             (pc),
        .gr_we          (gr_we),
        .dest           (dest),
        .result         (result),
        .is_csr_read    (is_csr_read),
        .csr_num        (csr_num),
        .csr_we         (csr_we),
        .csr_wmask      (csr_wmask),
        .csr_wvalue     (csr_wvalue),
        .ex_valid       (ex_valid),
        .ex_ecode       (ex_ecode),
        .ertn_valid     (ertn_valid),
        .wb_flush       (wb_flush)
    );

    csr_file u_csr (
        .clk          (clk),
        .reset        (reset),
        .csr_num      (csr_num),
        .csr_we       (csr_we),
        .csr_wmask    (csr_wmask),
        .csr_wvalue   (csr_wvalue),
        .ex_valid     (ex_valid),
        .ex_ecode     (ex_ecode),
        .ex_pc        (pc),
        .ertn_valid   (ertn_valid),
        .csr_rvalue   (csr_rvalue),
        .era_value    (era_value),
        .eentry_value (eentry_value)
    );

    wb_result u_result (
        .ws_valid     (ws_valid),
        .gr_we        (gr_we),
        .dest         (dest),
        .result       (result),
        .is_csr_read  (is_csr_read),
        .csr_rvalue   (csr_rvalue),
        .ex_valid     (ex_valid),
        .ertn_valid   (ertn_valid),
        .era_value    (era_value),
        .eentry_value (eentry_value),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .flush_pc     (flush_pc)
    );

endmodule

//--- sim/wb_tb_model.svh
`ifndef WB_TB_MODEL_SVH
`define WB_TB_MODEL_SVH

// one expected writeback per accepted item
typedef struct packed {
    logic      we;
    reg_addr_t addr;
    word_t     data;
    logic      flush;
    word_t     fpc;
} expect_t;

// CRMD PRMD ESTAT ERA EENTRY SAVE0..3
word_t   model_csr [9];
logic    prev_flush;
expect_t exp_q [$];
string   test_name;
int      err_count;
int      test_errs;
int      check_count;

function automatic int csr_slot(input csr_num_t num);
    case (num)
        14'h00:  return 0;
        14'h01:  return 1;
        14'h05:  return 2;
        14'h06:  return 3;
        14'h0c:  return 4;
        14'h30:  return 5;
        14'h31:  return 6;
        14'h32:  return 7;
        14'h33:  return 8;
        default: return -1;
    endcase
endfunction

function automatic word_t writable_bits(input int slot);
    case (slot)
        0, 1:    return 32'h0000_0007;
        2:       return 32'h0000_0003;
        4:       return 32'hffff_ffc0;
        default: return 32'hffff_ffff;
    endcase
endfunction

function automatic word_t ref_csr_read(input csr_num_t num);
    int slot;
    slot = csr_slot(num);
    if (slot < 0) begin
        return 32'h0;
    end
    return model_csr[slot];
endfunction

function automatic void ref_csr_update(input csr_num_t num, input word_t mask,
                                       input word_t value);
    int    slot;
    word_t m;
    slot = csr_slot(num);
    if (slot >= 0) begin
        m = mask & writable_bits(slot);
        model_csr[slot] = (model_csr[slot] & ~m) | (value & m);
    end
endfunction

// syscall > brk > adef > ine > ale
function automatic ecode_t ref_ecode(input csr_op_t op, input exc_flags_t exc);
    if (op == 3'd5) return 6'h0b;
    if (exc[2])     return 6'h0c;
    if (exc[3])     return 6'h08;
    if (exc[1])     return 6'h0d;
    if (exc[0])     return 6'h09;
    return 6'h00;
endfunction

task automatic check_rf(input logic exp_we, input reg_addr_t exp_addr, input word_t exp_data,
                        input logic act_we, input reg_addr_t act_addr, input word_t act_data);
    check_count++;
    if (act_we !== exp_we) begin
        $display("[FAIL] %s rf_we expected %0b actual %0b", test_name, exp_we, act_we);
        err_count++;
        test_errs++;
    end else if (exp_we && (act_addr !== exp_addr || act_data !== exp_data)) begin
        $display("[FAIL] %s rf write expected r%0d=%h actual r%0d=%h",
                 test_name, exp_addr, exp_data, act_addr, act_data);
        err_count++;
        test_errs++;
    end
endtask

task automatic check_flush(input logic exp_flag, input word_t exp_pc,
                           input logic act_flag, input word_t act_pc);
    check_count++;
    if (act_flag !== exp_flag) begin
        $display("[FAIL] %s wb_flush expected %0b actual %0b", test_name, exp_flag, act_flag);
        err_count++;
        test_errs++;
    end else if (exp_flag && act_pc !== exp_pc) begin
        $display("[FAIL] %s flush_pc expected %h actual %h", test_name, exp_pc, act_pc);
        err_count++;
        test_errs++;
    end
endtask

`endif

//--- sim/wb_tb.sv
`timescale 1ns/1ps

module wb_tb;
    import wb_pkg::*;

    logic       clk;
    logic       reset;
    logic       ms_to_ws_valid;
    word_t      ms_pc;
    logic       ms_gr_we;
    reg_addr_t  ms_dest;
    word_t      ms_result;
    csr_op_t    ms_op;
    csr_num_t   ms_csr_num;
    word_t      ms_rj_value;
    word_t      ms_rkd_value;
    exc_flags_t ms_exc;
    logic       ws_allowin;
    logic       rf_we;
    reg_addr_t  rf_waddr;
    word_t      rf_wdata;
    logic       wb_flush;
    word_t      flush_pc;

    `include "wb_tb_model.svh"

    // reset, then the six tests, plus a few drain cycles each
    localparam int STIM_CYCLES = 8 + 21 + 23 + 13 + 50 + 13 + 301 + 6 * 3;
    localparam int CYCLE_LIMIT = STIM_CYCLES + 50;

    int          cycles;
    int          test_count;
    logic        pending;
    expect_t     cur;

    wb_stage DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic expect_t predict(input csr_op_t op, input csr_num_t num, input logic gr_we,
                                        input reg_addr_t dest, input word_t result,
                                        input word_t rj, input word_t rkd,
                                        input exc_flags_t exc, input word_t pc);
        expect_t e;
        logic    ex;
        logic    is_csr;
        e = '0;
        // item arriving on the flush edge vanishes
        if (prev_flush) begin
            prev_flush = 1'b0;
            return e;
        end
        ex = (op == 3'd5) || (exc != 4'b0);
        is_csr = (op == 3'd1) || (op == 3'd2) || (op == 3'd3);
        e.we = gr_we && !ex;
        e.addr = dest;
        e.data = is_csr ? ref_csr_read(num) : result;
        e.flush = ex || (op == 3'd4);
        if (ex) begin
            e.fpc = model_csr[4];
            model_csr[1][2:0] = model_csr[0][2:0];
            model_csr[0][2:0] = 3'b000;
            model_csr[2][21:16] = ref_ecode(op, exc);
            model_csr[3] = pc;
        end else if (op == 3'd4) begin
            e.fpc = model_csr[3];
            model_csr[0][2:0] = model_csr[1][2:0];
        end else if (op == 3'd2) begin
            ref_csr_update(num, 32'hffff_ffff, rkd);
        end else if (op == 3'd3) begin
            ref_csr_update(num, rj, rkd);
        end
        prev_flush = e.flush;
        return e;
    endfunction

    task automatic send_item(input csr_op_t op, input csr_num_t num, input logic gr_we,
                             input word_t rj, input word_t rkd, input exc_flags_t exc);
        reg_addr_t dest;
        word_t     result;
        word_t     pc;
        dest = reg_addr_t'($urandom);
        result = $urandom;
        pc = $urandom & 32'hffff_fffc;
        @(negedge clk);
        ms_to_ws_valid = 1'b1;
        ms_op = op;
        ms_csr_num = num;
        ms_gr_we = gr_we;
        ms_dest = dest;
        ms_result = result;
        ms_rj_value = rj;
        ms_rkd_value = rkd;
        ms_exc = exc;
        ms_pc = pc;
        exp_q.push_back(predict(op, num, gr_we, dest, result, rj, rkd, exc, pc));
    endtask

    task automatic bubble();
        @(negedge clk);
        ms_to_ws_valid = 1'b0;
        // nothing lands on the flush edge, so the next item is kept
        prev_flush = 1'b0;
    endtask

    task automatic finish_test();
        bubble();
        while (exp_q.size() != 0 || pending) begin
            @(negedge clk);
        end
        $display("test %-10s done, %0d errors", test_name, test_errs);
        test_count++;
        test_errs = 0;
    endtask

    function automatic csr_num_t pick_csr();
        csr_num_t nums [9] = '{14'h00, 14'h01, 14'h05, 14'h06, 14'h0c,
                               14'h30, 14'h31, 14'h32, 14'h33};
        int k;
        k = int'($urandom_range(0, 9));
        if (k == 9) begin
            return csr_num_t'($urandom);
        end
        return nums[k];
    endfunction

    // outputs are sampled before the edge updates them
    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: simulation ran past %0d cycles", CYCLE_LIMIT);
            $display("*** FAILED ***");
            $finish;
        end else if (!reset) begin
            if (pending) begin
                check_rf(cur.we, cur.addr, cur.data, rf_we, rf_waddr, rf_wdata);
                check_flush(cur.flush, cur.fpc, wb_flush, flush_pc);
            end else begin
                check_rf(1'b0, 5'd0, 32'h0, rf_we, rf_waddr, rf_wdata);
                check_flush(1'b0, 32'h0, wb_flush, flush_pc);
            end
            if (!ws_allowin) begin
                $display("%s: ws_allowin went low, the stage must never stall", test_name);
                err_count++;
                test_errs++;
            end
            pending = 1'b0;
            if (ms_to_ws_valid && ws_allowin) begin
                if (exp_q.size() == 0) begin
                    $display("%s: item accepted with no expected result queued", test_name);
                    err_count++;
                    test_errs++;
                end else begin
                    cur = exp_q.pop_front();
                    pending = 1'b1;
                end
            end
        end
    end

    initial begin
        csr_num_t   nums [9] = '{14'h00, 14'h01, 14'h05, 14'h06, 14'h0c,
                                 14'h30, 14'h31, 14'h32, 14'h33};
        exc_flags_t combos [8] = '{4'b1000, 4'b0100, 4'b0010, 4'b0001,
                                   4'b1111, 4'b0101, 4'b1010, 4'b0000};
        void'($urandom(32'h0cbd_2ef9));
        cycles = 0;
        pending = 1'b0;
        err_count = 0;
        test_errs = 0;
        check_count = 0;
        test_count = 0;
        test_name = "reset";
        prev_flush = 1'b0;
        model_csr = '{32'h0000_0008, 0, 0, 0, 0, 0, 0, 0, 0};
        reset = 1'b1;
        ms_to_ws_valid = 1'b0;
        ms_pc = '0;
        ms_gr_we = 1'b0;
        ms_dest = '0;
        ms_result = '0;
        ms_op = OP_NONE;
        ms_csr_num = '0;
        ms_rj_value = '0;
        ms_rkd_value = '0;
        ms_exc = '0;
        repeat (8) @(negedge clk);
        reset = 1'b0;

        test_name = "retire";
        for (int i = 0; i < 20; i++) begin
            send_item(OP_NONE, 14'h0, 1'($urandom), 32'h0, 32'h0, 4'b0);
        end
        finish_test();

        test_name = "csrwr_rd";
        for (int i = 0; i < 9; i++) begin
            send_item(OP_CSRWR, nums[i], 1'b1, 32'h0, $urandom, 4'b0);
            send_item(OP_CSRRD, nums[i], 1'b1, 32'h0, 32'h0, 4'b0);
        end
        send_item(OP_CSRWR, 14'h02, 1'b1, 32'h0, $urandom, 4'b0);
        send_item(OP_CSRRD, 14'h02, 1'b1, 32'h0, 32'h0, 4'b0);
        send_item(OP_CSRWR, 14'h3fff, 1'b1, 32'h0, $urandom, 4'b0);
        send_item(OP_CSRRD, 14'h3fff, 1'b1, 32'h0, 32'h0, 4'b0);
        finish_test();

        test_name = "csrxchg";
        for (int i = 0; i < 12; i++) begin
            send_item(OP_CSRXCHG, nums[i % 9], 1'b1, $urandom, $urandom, 4'b0);
        end
        finish_test();

        test_name = "exception";
        send_item(OP_CSRWR, CSR_EENTRY, 1'b0, 32'h0, $urandom, 4'b0);
        for (int i = 0; i < 8; i++) begin
            send_item(OP_CSRWR, CSR_CRMD, 1'b0, 32'h0, $urandom, 4'b0);
            // last combo has no flags, so it is a plain syscall
            send_item((i >= 6) ? OP_SYSCALL : OP_NONE, 14'h0, 1'b1, 32'h0, 32'h0, combos[i]);
            bubble();
            send_item(OP_CSRRD, CSR_ERA, 1'b1, 32'h0, 32'h0, 4'b0);
            send_item(OP_CSRRD, CSR_ESTAT, 1'b1, 32'h0, 32'h0, 4'b0);
            send_item(OP_CSRRD, CSR_PRMD, 1'b1, 32'h0, 32'h0, 4'b0);
        end
        finish_test();

        test_name = "ertn";
        for (int i = 0; i < 2; i++) begin
            send_item(OP_CSRWR, CSR_PRMD, 1'b0, 32'h0, $urandom, 4'b0);
            send_item(OP_CSRWR, CSR_ERA, 1'b0, 32'h0, $urandom, 4'b0);
            send_item(OP_ERTN, 14'h0, 1'b0, 32'h0, 32'h0, 4'b0);
            send_item(OP_NONE, 14'h0, 1'b1, 32'h0, 32'h0, 4'b0);
            bubble();
            send_item(OP_CSRRD, CSR_CRMD, 1'b1, 32'h0, 32'h0, 4'b0);
        end
        finish_test();

        test_name = "random_mix";
        for (int i = 0; i < 300; i++) begin
            if ($urandom_range(0, 4) == 0) begin
                bubble();
            end else begin
                send_item(csr_op_t'($urandom_range(0, 5)), pick_csr(), 1'($urandom),
                          $urandom, $urandom,
                          ($urandom_range(0, 7) == 0) ? exc_flags_t'($urandom) : 4'b0);
            end
        end
        finish_test();

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+sim
hdl/wb_pkg.sv
hdl/wb_decode.sv
hdl/csr_file.sv
hdl/wb_result.sv
hdl/wb_stage.sv
sim/wb_tb.sv

//--- run.sh
#!/bin/sh
# build and run the writeback stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module wb_tb -o wb_sim \
    && ./obj_dir/wb_sim > sim.log \
    ; cat sim.log \
    && grep -qF '*** PASSED ***' sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
